// File: verilog/mean_params.svh
`ifndef MEAN_PARAMS_SVH
`define MEAN_PARAMS_SVH

// adc word width
// two's complement as it leaves the converter
`define ADC_W 24

// log2 of the window depth
// also the number of adder tree levels
`define WIN_LOG2 7

// window depth in samples
`define WIN_DEPTH (1 << `WIN_LOG2)

// width of the final tree sum
// each tree level adds one carry bit
`define SUM_W (`ADC_W + `WIN_LOG2)

// output mean width, zero extended from the shifted sum
`define MEAN_W 32

`endif

// File: verilog/mean_pkg.sv
`include "mean_params.svh"

package mean_pkg;

	// raw adc word as delivered by the converter
	// sample view is the signed value
	// fields view splits off the sign bit, used for offset binary
	typedef union packed
	{
		logic signed [`ADC_W-1:0] sample;
		struct packed
		{
			// msb of the two's complement word
			logic sign;
			// remaining bits, kept as is by the conversion
			logic [`ADC_W-2:0] mag;
		} fields;
	} adc_word_u;

	// offset binary sample
	// 0 is full scale negative, all ones is full scale positive
	typedef logic [`ADC_W-1:0] sample_t;

	// output mean, offset binary, upper bits always zero
	typedef logic [`MEAN_W-1:0] mean_t;

endpackage

// File: verilog/sample_window.sv
`timescale 1ns/1ns
`include "mean_params.svh"

module sample_window
(
	input  logic                           i_clk,
	input  logic                           i_rst,

	// adc side, one cycle strobe per word
	input  mean_pkg::adc_word_u            i_adc_data,
	input  logic                           i_adc_valid,

	// flat window, slot 0 in the low bits, slot 0 is newest
	output logic [`WIN_DEPTH*`ADC_W-1:0]   o_window,
	output logic                           o_valid
);

	// converted incoming word
	mean_pkg::sample_t conv_sample;

	// window storage
	mean_pkg::sample_t win_q [0:`WIN_DEPTH-1];

	// window changed on last edge
	logic valid_q;

	// offset binary conversion
	// flipping the sign bit maps -2^23..2^23-1 onto 0..2^24-1
	assign conv_sample = {~i_adc_data.fields.sign, i_adc_data.fields.mag};

	// shift register
	// every accepted word moves all entries up by one slot
	// oldest entry falls off the top
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			for (int i = 0; i < `WIN_DEPTH; i++)
			begin
				win_q[i] <= '0;
			end
		end
		else if (i_adc_valid)
		begin
			// newest sample into slot 0
			win_q[0] <= conv_sample;
			for (int i = 1; i < `WIN_DEPTH; i++)
			begin
				win_q[i] <= win_q[i-1];
			end
		end
	end

	// strobe registered on the same edge as the shift
	// the tree level 0 sees new window and strobe together
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= i_adc_valid;
		end
	end

	// pack window entries onto the flat bus
	genvar s;
	generate
		for (s = 0; s < `WIN_DEPTH; s = s + 1)
		begin : g_pack
			assign o_window[s*`ADC_W +: `ADC_W] = win_q[s];
		end
	endgenerate

	assign o_valid = valid_q;

endmodule

// File: verilog/sum_level.sv
`timescale 1ns/1ns

module sum_level
#(
	// number of terms coming in, must be even
	parameter int N_IN = 2,
	// width of one incoming term
	parameter int IN_W = 24
)
(
	input  logic                                i_clk,
	input  logic                                i_rst,

	// previous level
	input  logic                                i_valid,
	input  logic [N_IN*IN_W-1:0]                i_terms,

	// next level, half the terms, one bit wider
	output logic                                o_valid,
	output logic [(N_IN/2)*(IN_W+1)-1:0]        o_sums
);

	// pair count and sum width of this level
	localparam int N_OUT = N_IN / 2;
	localparam int OUT_W = IN_W + 1;

	// registered pair sums
	logic [OUT_W-1:0] sum_q [0:N_OUT-1];

	// strobe delayed by one level
	logic valid_q;

	genvar j;
	generate
		for (j = 0; j < N_OUT; j = j + 1)
		begin : g_pair
			// adjacent terms 2j and 2j+1
			logic [IN_W-1:0] term_a;
			logic [IN_W-1:0] term_b;

			assign term_a = i_terms[(2*j)*IN_W +: IN_W];
			assign term_b = i_terms[(2*j+1)*IN_W +: IN_W];

			// unsigned add with carry into the extra bit
			// held when no new window arrives
			always_ff @(posedge i_clk or negedge i_rst)
			begin
				if (!i_rst)
				begin
					sum_q[j] <= '0;
				end
				else if (i_valid)
				begin
					sum_q[j] <= {1'b0, term_a} + {1'b0, term_b};
				end
			end

			// pack onto the flat output
			assign o_sums[j*OUT_W +: OUT_W] = sum_q[j];
		end
	endgenerate

	// strobe follows the data one cycle later
	// so up to one result per level is in flight
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= i_valid;
		end
	end

	assign o_valid = valid_q;

endmodule

// File: verilog/mean_output.sv
`timescale 1ns/1ns
`include "mean_params.svh"

module mean_output
(
	input  logic                  i_clk,
	input  logic                  i_rst,

	// final tree sum
	input  logic                  i_valid,
	input  logic [`SUM_W-1:0]     i_sum,

	// mean and its strobe
	output mean_pkg::mean_t       o_mean,
	output logic                  o_valid
);

	// sum divided by the window depth
	logic [`SUM_W-1:0] sum_shift;

	// number of sums seen so far, stops at WIN_DEPTH-1
	logic [`WIN_LOG2-1:0] fill_cnt;

	// all ones once 127 sums have gone by
	logic window_full;

	mean_pkg::mean_t mean_q;
	logic valid_q;

	// window depth is a power of two, so divide is a shift
	assign sum_shift = i_sum >> `WIN_LOG2;

	assign window_full = &fill_cnt;

	// fill counter
	// saturates, so the next arriving sum is the 128th or later
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			fill_cnt <= '0;
		end
		else if (i_valid && !window_full)
		begin
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// mean register, updated on every arriving sum
	// holds between strobes
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			mean_q <= '0;
		end
		else if (i_valid)
		begin
			mean_q <= {{(`MEAN_W-`SUM_W){1'b0}}, sum_shift};
		end
	end

	// strobe only for sums from a full window
	// partial windows still hold reset zeros
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= i_valid && window_full;
		end
	end

	assign o_mean  = mean_q;
	assign o_valid = valid_q;

endmodule

// File: verilog/moving_mean.sv
`timescale 1ns/1ns
`include "mean_params.svh"

module moving_mean
(
	input  logic                  i_clk,
	input  logic                  i_rst,

	// adc input, valid for one cycle per word
	input  mean_pkg::adc_word_u   i_adc_data,
	input  logic                  i_adc_valid,

	// moving mean over the last 128 words
	output mean_pkg::mean_t       o_mean,
	output logic                  o_valid
);

	// window bus into tree level 0
	logic [`WIN_DEPTH*`ADC_W-1:0] window;
	logic window_valid;

	// single sum out of the last tree level
	logic [`SUM_W-1:0] total_sum;
	logic total_valid;

	// sample conversion and shift window, 1 cycle
	sample_window u_window
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_adc_data  (i_adc_data),
		.i_adc_valid (i_adc_valid),
		.o_window    (window),
		.o_valid     (window_valid)
	);

	// adder tree, one registered level per bit of window depth
	// level k takes 128>>k terms of 24+k bits
	genvar k;
	generate
		for (k = 0; k < `WIN_LOG2; k = k + 1)
		begin : g_level
			localparam int N_IN = `WIN_DEPTH >> k;
			localparam int IN_W = `ADC_W + k;

			// terms into this level
			logic [N_IN*IN_W-1:0] terms;
			logic terms_valid;

			// sums out of this level
			logic [(N_IN/2)*(IN_W+1)-1:0] sums;
			logic sums_valid;

			// level 0 reads the window, later levels read the level below
			if (k == 0)
			begin : g_first
				assign terms       = window;
				assign terms_valid = window_valid;
			end
			else
			begin : g_next
				assign terms       = g_level[k-1].sums;
				assign terms_valid = g_level[k-1].sums_valid;
			end

			sum_level
			#(
				.N_IN (N_IN),
				.IN_W (IN_W)
			)
			u_level
			(
				.i_clk   (i_clk),
				.i_rst   (i_rst),
				.i_valid (terms_valid),
				.i_terms (terms),
				.o_valid (sums_valid),
				.o_sums  (sums)
			);
		end
	endgenerate

	// last level leaves one 31 bit sum
	assign total_sum   = g_level[`WIN_LOG2-1].sums;
	assign total_valid = g_level[`WIN_LOG2-1].sums_valid;

	// divide, fill tracking and output strobe, 1 cycle
	// total latency from i_adc_valid to o_valid is 8 edges
	mean_output u_output
	(
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_valid (total_valid),
		.i_sum   (total_sum),
		.o_mean  (o_mean),
		.o_valid (o_valid)
	);

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen
(
	output logic o_clk,
	output logic o_rst
);

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// active low reset held for two rising edges
	// released just after the edge, like the stimulus
	initial
	begin
		o_rst = 1'b0;
		repeat (2) @(posedge o_clk);
		#1 o_rst = 1'b1;
	end

endmodule

// File: dv/moving_mean_properties.sv
`timescale 1ns/1ns

module moving_mean_properties
(
	input logic            i_clk,
	input logic            i_rst,
	input logic            i_adc_valid,
	input logic            i_out_valid,
	input mean_pkg::mean_t i_mean
);

	// set by the first strobe from a full window
	// before that the mean register tracks partial sums silently
	logic armed;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			armed <= 1'b0;
		end
		else if (i_out_valid)
		begin
			armed <= 1'b1;
		end
	end

	// no strobe while reset is applied
	a_no_valid_in_reset : assert property (@(posedge i_clk) !i_rst |-> !i_out_valid)
		else $error("o_valid high during reset");

	// strobe changes 8 edges after the input edge, seen one sample later
	a_valid_latency : assert property (@(posedge i_clk) disable iff (!i_rst)
		i_out_valid |-> $past(i_adc_valid, 9))
		else $error("o_valid without i_adc_valid eight edges before");

	// mean held between strobes once the window is full
	a_mean_held : assert property (@(posedge i_clk) disable iff (!i_rst)
		(armed && !i_out_valid) |-> $stable(i_mean))
		else $error("o_mean changed while o_valid low");

endmodule

bind moving_mean moving_mean_properties u_props
(
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_adc_valid (i_adc_valid),
	.i_out_valid (o_valid),
	.i_mean      (o_mean)
);

// File: dv/tb_moving_mean.sv
`timescale 1ns/1ns
`include "mean_params.svh"

module tb_moving_mean;

	logic                i_clk;
	logic                i_rst;
	mean_pkg::adc_word_u i_adc_data;
	logic                i_adc_valid;
	mean_pkg::mean_t     o_mean;
	logic                o_valid;

	// model state holding the last 128 converted samples and pending means
	mean_pkg::sample_t win_q [$];
	mean_pkg::mean_t   exp_q [$];
	int                n_exp;
	int                n_out;

	// output tracking for the hold check
	mean_pkg::mean_t   last_mean;
	bit                seen_out;

	int mismatch_cnt;
	int other_cnt;

	tb_clk_gen u_clk_gen
	(
		.o_clk (i_clk),
		.o_rst (i_rst)
	);

	moving_mean u_dut
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_adc_data  (i_adc_data),
		.i_adc_valid (i_adc_valid),
		.o_mean      (o_mean),
		.o_valid     (o_valid)
	);

	// reference model called once per accepted sample
	// sign flip done by xor
	// mean is the window sum over 128
	function automatic void model_sample(input mean_pkg::adc_word_u w);
		mean_pkg::sample_t conv;
		longint            sum;
		conv = w.sample ^ 24'h800000;
		win_q.push_back(conv);
		if (win_q.size() > `WIN_DEPTH)
			void'(win_q.pop_front());
		if (win_q.size() == `WIN_DEPTH)
		begin
			sum = 0;
			foreach (win_q[i])
				sum += win_q[i];
			exp_q.push_back(mean_pkg::mean_t'(sum >> `WIN_LOG2));
			n_exp++;
		end
	endfunction

	task automatic check_mean(input mean_pkg::mean_t got, input mean_pkg::mean_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
			mismatch_cnt++;
		end
	endtask

	// one sample with valid high for a single cycle
	task automatic send_sample(input logic [`ADC_W-1:0] value);
		mean_pkg::adc_word_u w;
		w.sample    = value;
		i_adc_data  = w;
		i_adc_valid = 1'b1;
		model_sample(w);
		@(posedge i_clk);
		#1 i_adc_valid = 1'b0;
	endtask

	// zero cycles keeps the current drive point
	task automatic idle(input int cycles);
		if (cycles > 0)
		begin
			repeat (cycles) @(posedge i_clk);
			#1;
		end
	endtask

	// wait until every queued mean has come out
	task automatic wait_drain(input string what);
		int cyc;
		for (cyc = 0; cyc < 40 && exp_q.size() != 0; cyc++)
			@(posedge i_clk);
		#1;
		if (exp_q.size() != 0)
		begin
			$display("timeout after %0t ns: %s still waits for %0d means", $time, what,
				exp_q.size());
			other_cnt++;
		end
	endtask

	// comparison process reads outputs at the falling edge
	always @(negedge i_clk)
	begin
		if (i_rst && o_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("error at %0t ns: o_valid high with no mean expected", $time);
				other_cnt++;
			end
			else
				check_mean(o_mean, exp_q.pop_front(), "mean");
			n_out++;
			last_mean = o_mean;
			seen_out  = 1'b1;
		end
		else if (i_rst && seen_out)
			check_mean(o_mean, last_mean, "held mean");
	end

	initial
	begin
		int cyc;
		i_adc_data  = '0;
		i_adc_valid = 1'b0;
		void'($urandom(47));

		for (cyc = 0; cyc < 10 && i_rst !== 1'b1; cyc++)
			@(posedge i_clk);
		#1;
		if (i_rst !== 1'b1)
		begin
			$display("timeout: reset never released");
			other_cnt++;
		end

		// quiet after reset with no strobe and a zero mean
		repeat (5)
		begin
			@(negedge i_clk);
			if (o_valid !== 1'b0)
			begin
				$display("error at %0t ns: o_valid high before any sample", $time);
				other_cnt++;
			end
			check_mean(o_mean, '0, "reset mean");
		end
		idle(1);

		// constant full scale negative then zero then full scale positive
		repeat (`WIN_DEPTH) send_sample(24'h800000);
		wait_drain("fill");
		check_count(n_out, 1, "outputs after fill");
		check_mean(last_mean, 32'h0, "negative full scale mean");
		repeat (`WIN_DEPTH) send_sample(24'h000000);
		wait_drain("zero");
		check_mean(last_mean, 32'h800000, "zero mean");
		repeat (`WIN_DEPTH) send_sample(24'h7FFFFF);
		wait_drain("positive");
		check_mean(last_mean, 32'hFFFFFF, "positive full scale mean");

		// back to back random words
		repeat (300) send_sample($urandom());
		wait_drain("back to back");

		// random gaps between words while the mean holds
		repeat (200)
		begin
			send_sample($urandom());
			idle($urandom_range(0, 5));
		end
		wait_drain("gaps");
		idle(10);

		check_count(n_out, n_exp, "output count");
		$display("errors: mismatch %0d, other %0d", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sources.f
+incdir+verilog
verilog/mean_pkg.sv
verilog/sample_window.sv
verilog/sum_level.sv
verilog/mean_output.sv
verilog/moving_mean.sv
dv/tb_clk_gen.sv
dv/moving_mean_properties.sv
dv/tb_moving_mean.sv
